// File: source/mmuPkg.sv
`default_nettype none

package mmuPkg;

	////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////

	// Word and address width of the CPU
	localparam int addrW = 32;
	localparam int wordW = 32;

	// Joint TLB geometry
	localparam int tlbEntries = 16;
	localparam int tlbIndexW = 4;

	// Field widths
	localparam int vpn2W = 19;
	localparam int asidW = 8;
	localparam int pfnW = 20;
	localparam int pageOffW = 12;

	////////////////////////////////////////////////////////////
	// Field positions in the cp0 words
	////////////////////////////////////////////////////////////

	// VPN2 sits in EntryHi 31:13 and ASID in 7:0
	localparam int hiVpn2Lsb = 13;
	localparam int hiAsidLsb = 0;

	// PFN sits in EntryLo 25:6 with D, V and G below it
	localparam int loPfnLsb = 6;
	localparam int loDirtyBit = 2;
	localparam int loValidBit = 1;
	localparam int loGlobalBit = 0;

	// Virtual address bit picking the odd page of a pair
	localparam int oddPageBit = 12;

	// kseg0/kseg1 share the top two bits 10
	localparam logic [1:0] ksegTop = 2'b10;
	// Bits dropped for the unmapped physical address
	localparam int segClearW = 3;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic dirty;
		logic valid;
	} pageBitsT;

	// One entry maps an even/odd page pair
	typedef struct packed {
		logic [vpn2W-1:0] vpn2;
		logic [asidW-1:0] asid;
		logic isGlobal;
		logic [pfnW-1:0] pfn0;
		pageBitsT bits0;
		logic [pfnW-1:0] pfn1;
		pageBitsT bits1;
	} tlbEntryT;

	typedef struct packed {
		logic [addrW-1:0] paddr;
		logic refill;
		logic invalid;
		logic modified;
	} translationT;

	typedef struct packed {
		logic miss;
		logic [tlbIndexW-1:0] index;
	} probeT;

	// Coprocessor 0 values as supplied by the CPU
	typedef struct packed {
		logic [wordW-1:0] index;
		logic [wordW-1:0] random;
		logic [wordW-1:0] entryHi;
		logic [wordW-1:0] entryLo0;
		logic [wordW-1:0] entryLo1;
	} cp0WordsT;

endpackage

`default_nettype wire

// File: source/tlbEntryArray.sv
`timescale 1ns/1ps
`default_nettype none

module tlbEntryArray (
	input wire logic clk,
	input wire logic rstN,
	input wire logic writeEn,
	input wire logic [mmuPkg::tlbIndexW-1:0] writeIndex,
	input wire logic [mmuPkg::wordW-1:0] entryHi,
	input wire logic [mmuPkg::wordW-1:0] entryLo0,
	input wire logic [mmuPkg::wordW-1:0] entryLo1,
	output mmuPkg::tlbEntryT [mmuPkg::tlbEntries-1:0] entriesFlat
);

	import mmuPkg::*;

	////////////////////////////////////////////////////////////
	// Entry packing
	////////////////////////////////////////////////////////////

	// Page attribute bits of one EntryLo word
	function automatic pageBitsT loBits(input logic [wordW-1:0] lo);
		pageBitsT b;
		b.dirty = lo[loDirtyBit];
		b.valid = lo[loValidBit];
		return b;
	endfunction

	// Entry as it will be stored
	tlbEntryT newEntry;

	always_comb begin
		// Tag half from EntryHi
		newEntry.vpn2 = entryHi[hiVpn2Lsb +: vpn2W];
		newEntry.asid = entryHi[hiAsidLsb +: asidW];

		// Global only if both pages say so
		newEntry.isGlobal = entryLo0[loGlobalBit] & entryLo1[loGlobalBit];

		// Even page
		newEntry.pfn0 = entryLo0[loPfnLsb +: pfnW];
		newEntry.bits0 = loBits(entryLo0);

		// Odd page
		newEntry.pfn1 = entryLo1[loPfnLsb +: pfnW];
		newEntry.bits1 = loBits(entryLo1);
	end

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	// One write port with the index chosen by the top level
	// Cleared entries have valid and dirty low on both pages
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			entriesFlat <= '0;
		end else if (writeEn) begin
			entriesFlat[writeIndex] <= newEntry;
		end
	end

	// Lookups read entriesFlat directly
	// New entry is visible from the cycle after the write edge

endmodule

`default_nettype wire

// File: source/tlbMatch.sv
`timescale 1ns/1ps
`default_nettype none

module tlbMatch (
	input wire mmuPkg::tlbEntryT [mmuPkg::tlbEntries-1:0] entriesFlat,
	input wire logic [mmuPkg::vpn2W-1:0] vpn2,
	input wire logic [mmuPkg::asidW-1:0] asid,
	output logic hit,
	output logic [mmuPkg::tlbIndexW-1:0] matchIndex,
	output mmuPkg::tlbEntryT matchEntry
);

	import mmuPkg::*;

	////////////////////////////////////////////////////////////
	// Per-entry compare
	////////////////////////////////////////////////////////////

	// One bit per entry
	logic [tlbEntries-1:0] matchVec;

	always_comb begin
		for (int i = 0; i < tlbEntries; i++) begin
			// Tag must agree
			// ASID ignored for global entries
			matchVec[i] = (entriesFlat[i].vpn2 == vpn2) &&
				(entriesFlat[i].isGlobal || (entriesFlat[i].asid == asid));
		end
	end

	////////////////////////////////////////////////////////////
	// Priority select
	////////////////////////////////////////////////////////////

	assign hit = |matchVec;

	// Scan from the top down so the lowest index is the last to land
	// Zero index and entry on a miss
	always_comb begin
		matchIndex = '0;
		matchEntry = '0;
		for (int i = tlbEntries - 1; i >= 0; i--) begin
			if (matchVec[i]) begin
				matchIndex = tlbIndexW'(i);
				matchEntry = entriesFlat[i];
			end
		end
	end

	// Several hits only happen when software writes duplicates
	// Real MIPS would take a machine check instead of picking the low index

endmodule

`default_nettype wire

// File: source/addrTranslator.sv
`timescale 1ns/1ps
`default_nettype none

module addrTranslator (
	input wire mmuPkg::tlbEntryT [mmuPkg::tlbEntries-1:0] entriesFlat,
	input wire logic [mmuPkg::addrW-1:0] vaddr,
	input wire logic [mmuPkg::asidW-1:0] asid,
	input wire logic isWrite,
	input wire logic checkFaults,
	output mmuPkg::translationT result
);

	import mmuPkg::*;

	////////////////////////////////////////////////////////////
	// Segment decode
	////////////////////////////////////////////////////////////

	// kseg0 and kseg1 bypass the TLB
	logic unmapped;

	assign unmapped = (vaddr[addrW-1 -: 2] == ksegTop);

	////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////

	logic hit;
	tlbEntryT hitEntry;

	// Translation only needs the entry, not its slot number
	tlbMatch match0 (
		.entriesFlat(entriesFlat),
		.vpn2(vaddr[hiVpn2Lsb +: vpn2W]),
		.asid(asid),
		.hit(hit),
		.matchIndex(),
		.matchEntry(hitEntry)
	);

	////////////////////////////////////////////////////////////
	// Even/odd page select
	////////////////////////////////////////////////////////////

	logic [pfnW-1:0] pagePfn;
	pageBitsT pageBits;

	always_comb begin
		if (vaddr[oddPageBit]) begin
			pagePfn = hitEntry.pfn1;
			pageBits = hitEntry.bits1;
		end else begin
			pagePfn = hitEntry.pfn0;
			pageBits = hitEntry.bits0;
		end
	end

	////////////////////////////////////////////////////////////
	// Result
	////////////////////////////////////////////////////////////

	// Mapped faults are all qualified by checkFaults
	logic mappedCheck;

	assign mappedCheck = checkFaults & ~unmapped;

	always_comb begin
		// Physical address
		if (unmapped) begin
			result.paddr = {{segClearW{1'b0}}, vaddr[addrW-segClearW-1:0]};
		end else begin
			result.paddr = {pagePfn, vaddr[pageOffW-1:0]};
		end

		// No entry for this page pair
		result.refill = mappedCheck & ~hit;

		// Entry found, chosen page not valid
		result.invalid = mappedCheck & hit & ~pageBits.valid;

		// Store to a clean page
		result.modified = mappedCheck & hit & pageBits.valid & isWrite &
			~pageBits.dirty;
	end

endmodule

`default_nettype wire

// File: source/mmu.sv
`timescale 1ns/1ps
`default_nettype none

module mmu (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [mmuPkg::addrW-1:0] iVaddr,
	input wire logic [mmuPkg::addrW-1:0] dVaddr,
	input wire logic [3:0] dwe,
	input wire logic drd,
	input wire logic tlbwi,
	input wire logic tlbwr,
	input wire logic tlbr,
	input wire logic tlbp,
	input wire mmuPkg::cp0WordsT cp0,
	output mmuPkg::translationT iTrans,
	output mmuPkg::translationT dTrans,
	output mmuPkg::tlbEntryT readEntry,
	output mmuPkg::probeT probe
);

	import mmuPkg::*;

	////////////////////////////////////////////////////////////
	// Entry array
	////////////////////////////////////////////////////////////

	tlbEntryT [tlbEntries-1:0] entriesFlat;
	logic writeEn;
	logic [tlbIndexW-1:0] writeIndex;

	// tlbwr takes the slot from Random, tlbwi from Index
	assign writeEn = tlbwi | tlbwr;
	assign writeIndex = tlbwr ? cp0.random[tlbIndexW-1:0] : cp0.index[tlbIndexW-1:0];

	tlbEntryArray entries0 (
		.clk(clk),
		.rstN(rstN),
		.writeEn(writeEn),
		.writeIndex(writeIndex),
		.entryHi(cp0.entryHi),
		.entryLo0(cp0.entryLo0),
		.entryLo1(cp0.entryLo1),
		.entriesFlat(entriesFlat)
	);

	// Current address space
	logic [asidW-1:0] curAsid;

	assign curAsid = cp0.entryHi[hiAsidLsb +: asidW];

	////////////////////////////////////////////////////////////
	// Translation ports
	////////////////////////////////////////////////////////////

	// Fetches always check
	addrTranslator iTrans0 (
		.entriesFlat(entriesFlat),
		.vaddr(iVaddr),
		.asid(curAsid),
		.isWrite(1'b0),
		.checkFaults(1'b1),
		.result(iTrans)
	);

	// Data side only faults on a real access
	logic dWrite;

	assign dWrite = |dwe;

	addrTranslator dTrans0 (
		.entriesFlat(entriesFlat),
		.vaddr(dVaddr),
		.asid(curAsid),
		.isWrite(dWrite),
		.checkFaults(drd | dWrite),
		.result(dTrans)
	);

	////////////////////////////////////////////////////////////
	// tlbp and tlbr
	////////////////////////////////////////////////////////////

	logic probeHit;
	logic [tlbIndexW-1:0] probeIndex;

	// Probe looks up EntryHi itself
	tlbMatch probeMatch0 (
		.entriesFlat(entriesFlat),
		.vpn2(cp0.entryHi[hiVpn2Lsb +: vpn2W]),
		.asid(curAsid),
		.hit(probeHit),
		.matchIndex(probeIndex),
		.matchEntry()
	);

	// Both results hold until their next strobe
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			readEntry <= '0;
			probe <= '{miss: 1'b1, index: '0};
		end else begin
			if (tlbr) begin
				readEntry <= entriesFlat[cp0.index[tlbIndexW-1:0]];
			end
			if (tlbp) begin
				probe <= '{miss: ~probeHit, index: probeIndex};
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/mmuChecker.sv
`timescale 1ns/1ps
`default_nettype none

module mmuChecker (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [mmuPkg::addrW-1:0] iVaddr,
	input wire logic [mmuPkg::addrW-1:0] dVaddr,
	input wire logic [3:0] dwe,
	input wire logic drd,
	input wire logic tlbwi,
	input wire logic tlbwr,
	input wire logic tlbr,
	input wire logic tlbp,
	input wire mmuPkg::translationT iTrans,
	input wire mmuPkg::translationT dTrans
);

	import mmuPkg::*;

	// Number of failed assertions
	int assertFails = 0;

	function automatic logic anyFlag(input translationT t);
		return t.refill | t.invalid | t.modified;
	endfunction

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////

	// One TLB instruction per cycle
	assert property (@(posedge clk) disable iff (!rstN) $onehot0({tlbwi, tlbwr, tlbr, tlbp}))
		else begin
			$error("More than one TLB strobe high in a cycle");
			assertFails++;
		end

	// Idle data port raises no flag
	assert property (@(posedge clk) disable iff (!rstN) (!drd && dwe == '0) |-> !anyFlag(dTrans))
		else begin
			$error("Data-side flag raised without an access");
			assertFails++;
		end

	// kseg0/kseg1 never fault on either port
	assert property (@(posedge clk) disable iff (!rstN)
		(iVaddr[addrW-1 -: 2] == ksegTop) |-> !anyFlag(iTrans))
		else begin
			$error("Unmapped fetch address faulted");
			assertFails++;
		end

	assert property (@(posedge clk) disable iff (!rstN)
		(dVaddr[addrW-1 -: 2] == ksegTop) |-> !anyFlag(dTrans))
		else begin
			$error("Unmapped data address faulted");
			assertFails++;
		end

endmodule

bind mmu mmuChecker checker0 (
	.clk(clk),
	.rstN(rstN),
	.iVaddr(iVaddr),
	.dVaddr(dVaddr),
	.dwe(dwe),
	.drd(drd),
	.tlbwi(tlbwi),
	.tlbwr(tlbwr),
	.tlbr(tlbr),
	.tlbp(tlbp),
	.iTrans(iTrans),
	.dTrans(dTrans)
);

`default_nettype wire

// File: bench/mmuTb.sv
`timescale 1ns/1ps
`default_nettype none

module mmuTb;

	import mmuPkg::*;

	// Clock period in ns
	localparam int clkPeriod = 40;
	localparam int randTests = 64;
	localparam int spareCycles = 10;

	////////////////////////////////////////////////////////////
	// DUT
	////////////////////////////////////////////////////////////

	logic clk;
	logic rstN;
	logic [addrW-1:0] iVaddr;
	logic [addrW-1:0] dVaddr;
	logic [3:0] dwe;
	logic drd;
	logic tlbwi;
	logic tlbwr;
	logic tlbr;
	logic tlbp;
	cp0WordsT cp0;
	translationT iTrans;
	translationT dTrans;
	tlbEntryT readEntry;
	probeT probe;

	mmu dut0 (
		.clk(clk),
		.rstN(rstN),
		.iVaddr(iVaddr),
		.dVaddr(dVaddr),
		.dwe(dwe),
		.drd(drd),
		.tlbwi(tlbwi),
		.tlbwr(tlbwr),
		.tlbr(tlbr),
		.tlbp(tlbp),
		.cp0(cp0),
		.iTrans(iTrans),
		.dTrans(dTrans),
		.readEntry(readEntry),
		.probe(probe)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Vector storage and bookkeeping
	////////////////////////////////////////////////////////////

	string vecName[$];
	string vecOp[$];
	cp0WordsT vecCp0[$];
	logic [addrW-1:0] vecIAddr[$];
	logic [addrW-1:0] vecDAddr[$];
	logic [3:0] vecDwe[$];
	logic vecDrd[$];
	logic [71:0] vecExpA[$];
	logic [71:0] vecExpB[$];

	int passCnt;
	int failCnt;
	logic testOk;
	logic [31:0] rngState;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// One test per line and comment lines start with #
	task automatic loadVectors();
		int fd;
		int n;
		string line;
		string nm;
		string op;
		logic [31:0] idx;
		logic [31:0] rnd;
		logic [31:0] hi;
		logic [31:0] lo0;
		logic [31:0] lo1;
		logic [31:0] ia;
		logic [31:0] da;
		logic [31:0] we;
		logic [31:0] rd;
		logic [71:0] ea;
		logic [71:0] eb;
		cp0WordsT c;
		fd = $fopen("bench/mmuVectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file bench/mmuVectors.txt");
			failCnt++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h", nm, op,
						idx, rnd, hi, lo0, lo1, ia, da, we, rd, ea, eb);
					if (n != 13) begin
						$display("Malformed vector line: %s", line);
						failCnt++;
					end else begin
						c.index = idx;
						c.random = rnd;
						c.entryHi = hi;
						c.entryLo0 = lo0;
						c.entryLo1 = lo1;
						vecName.push_back(nm);
						vecOp.push_back(op);
						vecCp0.push_back(c);
						vecIAddr.push_back(ia);
						vecDAddr.push_back(da);
						vecDwe.push_back(we[3:0]);
						vecDrd.push_back(rd[0]);
						vecExpA.push_back(ea);
						vecExpB.push_back(eb);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic driveIdle();
		iVaddr = '0;
		dVaddr = '0;
		dwe = '0;
		drd = 1'b0;
		tlbwi = 1'b0;
		tlbwr = 1'b0;
		tlbr = 1'b0;
		tlbp = 1'b0;
		cp0 = '0;
	endtask

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkTrans(input string name, input translationT expT, input translationT actT);
		if (actT !== expT) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expT, actT);
			testOk = 1'b0;
		end
	endtask

	task automatic checkEntry(input string name, input tlbEntryT expE, input tlbEntryT actE);
		if (actE !== expE) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expE, actE);
			testOk = 1'b0;
		end
	endtask

	task automatic checkProbe(input string name, input probeT expP, input probeT actP);
		if (actP !== expP) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expP, actP);
			testOk = 1'b0;
		end
	endtask

	task automatic finishTest(input string name);
		if (testOk) begin
			passCnt++;
			$display("[PASS] %s", name);
		end else begin
			failCnt++;
			$display("[FAIL] %s", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test runners
	////////////////////////////////////////////////////////////

	// Drive on this falling edge and check on the next one
	task automatic runVector(input int k);
		translationT expI;
		translationT expD;
		tlbEntryT expE;
		probeT expP;
		cp0 = vecCp0[k];
		iVaddr = vecIAddr[k];
		dVaddr = vecDAddr[k];
		dwe = vecDwe[k];
		drd = vecDrd[k];
		tlbwi = (vecOp[k] == "write");
		tlbwr = (vecOp[k] == "rwrite");
		tlbr = (vecOp[k] == "read");
		tlbp = (vecOp[k] == "probe");
		expI = vecExpA[k][$bits(translationT)-1:0];
		expD = vecExpB[k][$bits(translationT)-1:0];
		expE = vecExpA[k];
		expP = vecExpA[k][$bits(probeT)-1:0];
		testOk = 1'b1;
		@(negedge clk);
		// Registers loaded at the rising edge in between
		if (vecOp[k] == "translate") begin
			checkTrans({vecName[k], " iTrans"}, expI, iTrans);
			checkTrans({vecName[k], " dTrans"}, expD, dTrans);
		end else if (vecOp[k] == "read") begin
			checkEntry(vecName[k], expE, readEntry);
		end else if (vecOp[k] == "probe") begin
			checkProbe(vecName[k], expP, probe);
		end else if (vecOp[k] != "write" && vecOp[k] != "rwrite") begin
			$display("Unknown operation %s in test %s", vecOp[k], vecName[k]);
			testOk = 1'b0;
		end
		finishTest(vecName[k]);
	endtask

	// kseg0/kseg1 addresses map to their low 29 bits
	task automatic runRandom(input int n);
		translationT expI;
		translationT expD;
		rngState = xorshift32(rngState);
		iVaddr = {2'b10, rngState[29:0]};
		rngState = xorshift32(rngState);
		dVaddr = {2'b10, rngState[29:0]};
		rngState = xorshift32(rngState);
		dwe = rngState[3:0];
		drd = rngState[4];
		expI = '0;
		expD = '0;
		expI.paddr = {3'b000, iVaddr[28:0]};
		expD.paddr = {3'b000, dVaddr[28:0]};
		testOk = 1'b1;
		@(negedge clk);
		checkTrans($sformatf("rand%0d iTrans", n), expI, iTrans);
		checkTrans($sformatf("rand%0d dTrans", n), expD, dTrans);
		finishTest($sformatf("rand%0d", n));
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int total;
		probeT expResetProbe;
		passCnt = 0;
		failCnt = 0;
		rngState = 32'd98216;
		rstN = 1'b0;
		driveIdle();
		loadVectors();
		total = vecName.size() + randTests + spareCycles;

		// Watchdog sized from the test count
		fork
			begin
				#(total * clkPeriod);
				$display("Timeout: the run did not end within %0d clock cycles", total);
				$display("Something failed");
				$finish;
			end
		join_none

		repeat (2) @(negedge clk);

		// Read and probe registers come out of reset empty
		expResetProbe.miss = 1'b1;
		expResetProbe.index = '0;
		testOk = 1'b1;
		checkEntry("resetState readEntry", '0, readEntry);
		checkProbe("resetState probe", expResetProbe, probe);
		finishTest("resetState");
		rstN = 1'b1;

		foreach (vecName[k]) runVector(k);
		for (int n = 0; n < randTests; n++) runRandom(n);
		driveIdle();

		// Assertion failures from the bound checker
		if (dut0.checker0.assertFails != 0) begin
			$display("Assertions failed %0d times", dut0.checker0.assertFails);
			failCnt += dut0.checker0.assertFails;
		end
		$display("Tests passed: %0d, failed: %0d", passCnt, failCnt);
		if (failCnt == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/mmuVectors.txt
# name op index random entryHi entryLo0 entryLo1 iVaddr dVaddr dwe drd expA expB (hex)
# expA/expB: iTrans/dTrans for translate, tlbEntryT or probeT in expA for read/probe
ksegBoot translate 0 0 00000000 00000000 00000000 80001234 A0405678 0 1 0000091A0 00202B3C0
ksegTop translate 0 0 00000000 00000000 00000000 BFFFFFFC 9ABCDEF0 F 0 0FFFFFFE0 0D5E6F780
probeEmpty probe 0 0 00400002 00000000 00000000 00000000 00000000 0 0 10 0
missEmpty translate 0 0 00400002 00000000 00000000 00400ABC 00401DEF 0 1 0000055E4 000006F7C
wrEntry0 write 0 0 00400002 00800006 00800046 00000000 00000000 0 0 0 0
mapPair translate 0 0 00400002 00000000 00000000 00400ABC 00401DEF 0 1 1000055E0 10000EF78
asidMiss translate 0 0 00400005 00000000 00000000 00400ABC 00400ABC 0 0 0000055E4 0000055E0
wrGlobal write 1 0 00800003 00C00007 00C00047 00000000 00000000 0 0 0 0
globalAnyAsid translate 0 0 00000005 00000000 00000000 00800123 00801456 F 0 180000918 18000A2B0
wrFaulty write 2 0 00C00002 01000000 01000042 00000000 00000000 0 0 0 0
invalidAndMod translate 0 0 00000002 00000000 00000000 00C00010 00C01020 1 0 200000082 200008101
cleanRead translate 0 0 00000002 00000000 00000000 80000000 00C01020 0 1 000000000 200008100
dataIdle translate 0 0 00000002 00000000 00000000 00C00010 00C00010 0 0 200000082 200000080
invalidData translate 0 0 00000002 00000000 00000000 00C01020 00C00010 0 1 200008100 200000082
readEntry0 read 0 0 00000000 00000000 00000000 00000000 00000000 0 0 004000420000C80007 0
readGlobal read 1 0 00000000 00000000 00000000 00000000 00000000 0 0 008000730000CC0007 0
readFaulty read 2 0 00000000 00000000 00000000 00000000 00000000 0 0 00C000440000100005 0
wrRandom rwrite 0 9 01000007 00000403 00000446 00000000 00000000 0 0 0 0
readRandom read 9 0 00000000 00000000 00000000 00000000 00000000 0 0 010000E00010400047 0
readKept read 0 0 00000000 00000000 00000000 00000000 00000000 0 0 004000420000C80007 0
probeHit probe 0 0 00400002 00000000 00000000 00000000 00000000 0 0 00 0
probeAsidMiss probe 0 0 00400005 00000000 00000000 00000000 00000000 0 0 10 0
probeGlobal probe 0 0 00800009 00000000 00000000 00000000 00000000 0 0 01 0
wrDup write 6 0 00C00002 01000000 01000042 00000000 00000000 0 0 0 0
probeDup probe 0 0 00C00002 00000000 00000000 00000000 00000000 0 0 02 0
probeRandom probe 0 0 01000007 00000000 00000000 00000000 00000000 0 0 09 0
mapRandom translate 0 0 00000007 00000000 00000000 01000004 01001008 3 0 000080020 000088040

// File: mmu.f
source/mmuPkg.sv
source/tlbEntryArray.sv
source/tlbMatch.sv
source/addrTranslator.sv
source/mmu.sv
bench/mmuChecker.sv
bench/mmuTb.sv

// File: Bender.yml
package:
  name: mmu

sources:
  - source/mmuPkg.sv
  - source/tlbEntryArray.sv
  - source/tlbMatch.sv
  - source/addrTranslator.sv
  - source/mmu.sv
  - target: test
    files:
      - bench/mmuChecker.sv
      - bench/mmuTb.sv
